// ==== hdl/rv_core_pkg.sv ====
// Widths, control encodings and AHB-lite constants shared by every block of the RV32I core
package rv_core_pkg;

	// ====================
	// Widths
	// ====================
	localparam int XLEN       = 32;
	localparam int N_REGS     = 32;
	localparam int REG_ADDR_W = $clog2(N_REGS);

	// ====================
	// Encodings
	// ====================

	// Major opcodes the core executes, anything else decodes as a NOP
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} alu_op_e;

	typedef enum logic [1:0] {
		NONE,
		LW,
		SW
	} mem_op_e;

	typedef enum logic {
		RS2,
		IMM
	} src_b_e;

	// Only single transfers, so no SEQ or BUSY
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		NONSEQ = 2'b10
	} htrans_e;

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INSTR  = 32'h0000_0013;
	localparam logic [2:0]      HSIZE_WORD = 3'b010;

endpackage

// ==== hdl/rv_fetch.sv ====
// Fetch stage, issues sequential word fetches and queues up to two instructions for decode
module rv_fetch import rv_core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            fetch_grant_i,
	input  logic            fetch_rdata_valid_i,
	input  logic [XLEN-1:0] hrdata_i,
	input  logic            instr_take_i,
	output logic            fetch_req_o,
	output logic [XLEN-1:0] fetch_addr_o,
	output logic            instr_valid_o,
	output logic [XLEN-1:0] instr_o
);

	logic [XLEN-1:0] q_data [2];
	logic [1:0]      q_cnt;
	logic            in_flight;
	logic            started;
	logic            push;
	logic            pop;
	logic            wr_idx;

	assign push = fetch_rdata_valid_i;
	assign pop  = instr_valid_o && instr_take_i;

	// Slot the incoming word lands in, after this cycle's pop
	assign wr_idx = q_cnt[1] || (q_cnt[0] && !pop);

	assign instr_valid_o = q_cnt != 2'd0;
	assign instr_o       = instr_valid_o ? q_data[0] : NOP_INSTR;

	// Queued plus in-flight words never exceed the two queue slots
	// Bus stays idle in the first cycle out of reset
	assign fetch_req_o = started && (q_cnt + 2'(in_flight) < 2'd2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started      <= 1'b0;
			in_flight    <= 1'b0;
			q_cnt        <= 2'd0;
			fetch_addr_o <= RESET_VECTOR;
		end else begin
			started   <= 1'b1;
			in_flight <= fetch_grant_i || (in_flight && !fetch_rdata_valid_i);
			q_cnt     <= q_cnt + 2'(push) - 2'(pop);
			if (fetch_grant_i) begin
				fetch_addr_o <= fetch_addr_o + XLEN'(4);
			end
		end
	end

	// Head shifts out on a pop, new word goes behind whatever remains
	always_ff @(posedge clk) begin
		if (pop) begin
			q_data[0] <= q_data[1];
		end
		if (push) begin
			q_data[wr_idx] <= hrdata_i;
		end
	end

	// Decode must drain a full queue in the cycle another word arrives
	assert property (@(posedge clk) disable iff (!rst_n)
		q_cnt == 2'd2 && push |-> pop);

endmodule

// ==== hdl/rv_decode.sv ====
// Decode stage, turns a queued instruction into control enums and loads the D-to-X registers
module rv_decode import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid_i,
	input  logic [XLEN-1:0]       instr_i,
	input  logic                  x_stall_i,
	output logic                  instr_take_o,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	output logic [REG_ADDR_W-1:0] dx_rs1_o,
	output logic [REG_ADDR_W-1:0] dx_rs2_o,
	output logic [REG_ADDR_W-1:0] dx_rd_o,
	output logic [XLEN-1:0]       dx_imm_o,
	output alu_op_e               dx_alu_op_o,
	output src_b_e                dx_src_b_o,
	output mem_op_e               dx_mem_op_o
);

	logic [REG_ADDR_W-1:0] d_rs1;
	logic [REG_ADDR_W-1:0] d_rs2;
	logic [REG_ADDR_W-1:0] d_rd;
	logic [XLEN-1:0]       d_imm;
	alu_op_e               d_alu_op;
	src_b_e                d_src_b;
	mem_op_e               d_mem_op;
	logic                  d_nop;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_s;
	logic [XLEN-1:0]       imm_u;

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_u = {instr_i[31:12], 12'h000};

	// Bit 30 selects SUB (register form only) and the arithmetic right shift
	function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt,
			input logic is_reg);
		case (funct3)
			3'b000:  return (alt && is_reg) ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b011:  return SLTU;
			3'b100:  return XOR;
			3'b101:  return alt ? SRA : SRL;
			3'b110:  return OR;
			default: return AND;
		endcase
	endfunction

	always_comb begin
		d_rs1    = instr_i[19:15];
		d_rs2    = instr_i[24:20];
		d_rd     = instr_i[11:7];
		d_imm    = imm_i;
		d_alu_op = alu_from_funct(instr_i[14:12], instr_i[30], 1'b0);
		d_src_b  = IMM;
		d_mem_op = NONE;
		d_nop    = !instr_valid_i;
		// Unused register fields are zeroed to keep them out of bypass and hazard checks
		case (instr_i[6:0])
			OP: begin
				d_alu_op = alu_from_funct(instr_i[14:12], instr_i[30], 1'b1);
				d_src_b  = RS2;
			end
			OP_IMM: d_rs2 = '0;
			LUI: begin
				d_rs1    = '0;
				d_rs2    = '0;
				d_imm    = imm_u;
				d_alu_op = ADD;
			end
			LOAD: begin
				d_rs2    = '0;
				d_alu_op = ADD;
				d_mem_op = LW;
				d_nop    = d_nop || instr_i[14:12] != 3'b010;
			end
			STORE: begin
				d_rd     = '0;
				d_imm    = imm_s;
				d_alu_op = ADD;
				d_mem_op = SW;
				d_nop    = d_nop || instr_i[14:12] != 3'b010;
			end
			default: d_nop = 1'b1;
		endcase
		if (d_nop) begin
			d_rs1    = '0;
			d_rs2    = '0;
			d_rd     = '0;
			d_mem_op = NONE;
		end
	end

	assign instr_take_o = instr_valid_i && !x_stall_i;

	// A held instruction rereads its own operands so late writes still reach X
	assign rs1_addr_o = x_stall_i ? dx_rs1_o : d_rs1;
	assign rs2_addr_o = x_stall_i ? dx_rs2_o : d_rs2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_rs1_o    <= '0;
			dx_rs2_o    <= '0;
			dx_rd_o     <= '0;
			dx_mem_op_o <= NONE;
		end else if (!x_stall_i) begin
			dx_rs1_o    <= d_rs1;
			dx_rs2_o    <= d_rs2;
			dx_rd_o     <= d_rd;
			dx_mem_op_o <= d_mem_op;
		end
	end

	always_ff @(posedge clk) begin
		if (!x_stall_i) begin
			dx_imm_o    <= d_imm;
			dx_alu_op_o <= d_alu_op;
			dx_src_b_o  <= d_src_b;
		end
	end

endmodule

// ==== hdl/rv_regfile.sv ====
// Integer register file, one write port and two read ports registered for D-to-X timing
module rv_regfile import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	input  logic [REG_ADDR_W-1:0] wr_addr_i,
	input  logic [XLEN-1:0]       wr_data_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o
);

	logic [XLEN-1:0] regs [N_REGS];

	// x0 is hardwired, writes to it are dropped
	always_ff @(posedge clk) begin
		if (wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// Read returns the old value on a same-cycle write, X covers that case
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs1_data_o <= '0;
			rs2_data_o <= '0;
		end else begin
			rs1_data_o <= regs[rs1_addr_i];
			rs2_data_o <= regs[rs2_addr_i];
		end
	end

endmodule

// ==== hdl/rv_execute.sv ====
// Execute stage with operand bypass, ALU, load-use detection and the X-to-M registers
module rv_execute import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] dx_rs1_i,
	input  logic [REG_ADDR_W-1:0] dx_rs2_i,
	input  logic [REG_ADDR_W-1:0] dx_rd_i,
	input  logic [XLEN-1:0]       dx_imm_i,
	input  alu_op_e               dx_alu_op_i,
	input  src_b_e                dx_src_b_i,
	input  mem_op_e               dx_mem_op_i,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	input  logic [REG_ADDR_W-1:0] mw_rd_i,
	input  logic [XLEN-1:0]       mw_result_i,
	input  logic [REG_ADDR_W-1:0] wx_rd_i,
	input  logic [XLEN-1:0]       wx_result_i,
	input  logic                  m_stall_i,
	output logic                  x_stall_o,
	output logic                  data_req_o,
	output logic [XLEN-1:0]       data_addr_o,
	output logic                  data_write_o,
	output logic [REG_ADDR_W-1:0] xm_rd_o,
	output logic [REG_ADDR_W-1:0] xm_rs2_o,
	output logic [XLEN-1:0]       xm_result_o,
	output logic [XLEN-1:0]       xm_store_data_o,
	output mem_op_e               xm_mem_op_o
);

	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_result;
	logic            load_use;

	// ====================
	// Bypass
	// ====================

	// Youngest producer wins, the post-writeback copy stands in for a regfile bypass
	function automatic logic [XLEN-1:0] bypass(input logic [REG_ADDR_W-1:0] idx,
			input logic [XLEN-1:0] rf_data);
		if (idx == '0) begin
			return '0;
		end
		if (idx == xm_rd_o) begin
			return xm_result_o;
		end
		if (idx == mw_rd_i) begin
			return mw_result_i;
		end
		if (idx == wx_rd_i) begin
			return wx_result_i;
		end
		return rf_data;
	endfunction

	always_comb begin
		rs1_val = bypass(dx_rs1_i, rs1_data_i);
		rs2_val = bypass(dx_rs2_i, rs2_data_i);
	end

	assign op_b = (dx_src_b_i == IMM) ? dx_imm_i : rs2_val;

	// ====================
	// ALU
	// ====================
	always_comb begin
		case (dx_alu_op_i)
			ADD:     alu_result = rs1_val + op_b;
			SUB:     alu_result = rs1_val - op_b;
			SLL:     alu_result = rs1_val << op_b[4:0];
			SLT:     alu_result = XLEN'($signed(rs1_val) < $signed(op_b));
			SLTU:    alu_result = XLEN'(rs1_val < op_b);
			XOR:     alu_result = rs1_val ^ op_b;
			SRL:     alu_result = rs1_val >> op_b[4:0];
			SRA:     alu_result = $signed(rs1_val) >>> op_b[4:0];
			OR:      alu_result = rs1_val | op_b;
			AND:     alu_result = rs1_val & op_b;
			default: alu_result = '0;
		endcase
	end

	// ====================
	// Hazards and bus request
	// ====================

	// Store data gets the loaded word in M, so only the store address must wait
	assign load_use = xm_mem_op_o == LW && xm_rd_o != '0 &&
		(xm_rd_o == dx_rs1_i || (xm_rd_o == dx_rs2_i && dx_mem_op_i != SW));

	assign x_stall_o = load_use || m_stall_i;

	// Not gated by m_stall, a wait state simply extends the address phase
	assign data_req_o   = dx_mem_op_i != NONE && !load_use;
	assign data_addr_o  = alu_result;
	assign data_write_o = dx_mem_op_i == SW;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm_rd_o     <= '0;
			xm_rs2_o    <= '0;
			xm_mem_op_o <= NONE;
		end else if (!m_stall_i) begin
			if (load_use) begin
				xm_rd_o     <= '0;
				xm_rs2_o    <= '0;
				xm_mem_op_o <= NONE;
			end else begin
				xm_rd_o     <= dx_rd_i;
				xm_rs2_o    <= dx_rs2_i;
				xm_mem_op_o <= dx_mem_op_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!m_stall_i) begin
			xm_result_o     <= alu_result;
			xm_store_data_o <= rs2_val;
		end
	end

	// Load-use bubble issues no bus access and clears once the load leaves M
	assert property (@(posedge clk) disable iff (!rst_n)
		load_use && !m_stall_i |-> !data_req_o ##1 !load_use);

endmodule

// ==== hdl/rv_mem_stage.sv ====
// Memory stage, drives store write data and holds the M-to-W and post-writeback registers
module rv_mem_stage import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] xm_rd_i,
	input  logic [REG_ADDR_W-1:0] xm_rs2_i,
	input  logic [XLEN-1:0]       xm_result_i,
	input  logic [XLEN-1:0]       xm_store_data_i,
	input  mem_op_e               xm_mem_op_i,
	input  logic [XLEN-1:0]       hrdata_i,
	input  logic                  m_stall_i,
	output logic [XLEN-1:0]       hwdata_o,
	output logic [REG_ADDR_W-1:0] mw_rd_o,
	output logic [XLEN-1:0]       mw_result_o,
	output logic [REG_ADDR_W-1:0] wx_rd_o,
	output logic [XLEN-1:0]       wx_result_o
);

	// Covers a load directly ahead of the store, whose data was not ready in X
	assign hwdata_o = (mw_rd_o != '0 && xm_rs2_i == mw_rd_o) ? mw_result_o : xm_store_data_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mw_rd_o <= '0;
			wx_rd_o <= '0;
		end else if (!m_stall_i) begin
			mw_rd_o <= xm_rd_i;
			wx_rd_o <= mw_rd_o;
		end
	end

	always_ff @(posedge clk) begin
		if (!m_stall_i) begin
			mw_result_o <= (xm_mem_op_i == LW) ? hrdata_i : xm_result_i;
			wx_result_o <= mw_result_o;
		end
	end

endmodule

// ==== hdl/rv_ahb_master.sv ====
// AHB-lite master, arbitrates fetch against data and tracks who owns the data phase
module rv_ahb_master import rv_core_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            hready_i,
	input  logic            data_req_i,
	input  logic [XLEN-1:0] data_addr_i,
	input  logic            data_write_i,
	input  logic            fetch_req_i,
	input  logic [XLEN-1:0] fetch_addr_i,
	output htrans_e         htrans_o,
	output logic [XLEN-1:0] haddr_o,
	output logic            hwrite_o,
	output logic [2:0]      hsize_o,
	output logic            fetch_grant_o,
	output logic            fetch_rdata_valid_o,
	output logic            m_stall_o
);

	logic dph_fetch;
	logic dph_data;

	// Address phase, data always wins and hready stays out of htrans
	assign htrans_o = (data_req_i || fetch_req_i) ? NONSEQ : IDLE;
	assign haddr_o  = data_req_i ? data_addr_i : fetch_addr_i;
	assign hwrite_o = data_req_i && data_write_i;
	assign hsize_o  = HSIZE_WORD;

	assign fetch_grant_o       = fetch_req_i && !data_req_i && hready_i;
	assign fetch_rdata_valid_o = dph_fetch && hready_i;

	// Also holds X when its own address phase is not accepted yet
	assign m_stall_o = !hready_i && (dph_data || data_req_i);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_fetch <= 1'b0;
			dph_data  <= 1'b0;
		end else if (hready_i) begin
			dph_data  <= data_req_i;
			dph_fetch <= fetch_req_i && !data_req_i;
		end
	end

	// One owner per data phase
	assert property (@(posedge clk) disable iff (!rst_n)
		!(dph_fetch && dph_data));

endmodule

// ==== hdl/rv_core.sv ====
// Top level of the five-stage RV32I core, instantiate with RESET_VECTOR and hook to an AHB-lite slave
module rv_core import rv_core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            ahb_hready_i,
	input  logic [XLEN-1:0] ahb_hrdata_i,
	output logic [XLEN-1:0] ahb_haddr_o,
	output logic            ahb_hwrite_o,
	output htrans_e         ahb_htrans_o,
	output logic [2:0]      ahb_hsize_o,
	output logic [XLEN-1:0] ahb_hwdata_o
);

	// ====================
	// F and D
	// ====================
	logic                  fetch_req;
	logic [XLEN-1:0]       fetch_addr;
	logic                  fetch_grant;
	logic                  fetch_rdata_valid;
	logic                  instr_valid;
	logic [XLEN-1:0]       instr;
	logic                  instr_take;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [REG_ADDR_W-1:0] dx_rs1;
	logic [REG_ADDR_W-1:0] dx_rs2;
	logic [REG_ADDR_W-1:0] dx_rd;
	logic [XLEN-1:0]       dx_imm;
	alu_op_e               dx_alu_op;
	src_b_e                dx_src_b;
	mem_op_e               dx_mem_op;

	// ====================
	// X, M and W
	// ====================
	logic                  x_stall;
	logic                  m_stall;
	logic                  data_req;
	logic [XLEN-1:0]       data_addr;
	logic                  data_write;
	logic [REG_ADDR_W-1:0] xm_rd;
	logic [REG_ADDR_W-1:0] xm_rs2;
	logic [XLEN-1:0]       xm_result;
	logic [XLEN-1:0]       xm_store_data;
	mem_op_e               xm_mem_op;
	logic [REG_ADDR_W-1:0] mw_rd;
	logic [XLEN-1:0]       mw_result;
	logic [REG_ADDR_W-1:0] wx_rd;
	logic [XLEN-1:0]       wx_result;

	rv_fetch #(.RESET_VECTOR(RESET_VECTOR)) u_fetch (
		.clk(clk), .rst_n(rst_n),
		.fetch_grant_i(fetch_grant), .fetch_rdata_valid_i(fetch_rdata_valid),
		.hrdata_i(ahb_hrdata_i), .instr_take_i(instr_take),
		.fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
		.instr_valid_o(instr_valid), .instr_o(instr)
	);

	rv_decode u_decode (
		.clk(clk), .rst_n(rst_n),
		.instr_valid_i(instr_valid), .instr_i(instr), .x_stall_i(x_stall),
		.instr_take_o(instr_take), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
		.dx_rs1_o(dx_rs1), .dx_rs2_o(dx_rs2), .dx_rd_o(dx_rd), .dx_imm_o(dx_imm),
		.dx_alu_op_o(dx_alu_op), .dx_src_b_o(dx_src_b), .dx_mem_op_o(dx_mem_op)
	);

	rv_regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
		.wr_addr_i(mw_rd), .wr_data_i(mw_result),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
	);

	rv_execute u_execute (
		.clk(clk), .rst_n(rst_n),
		.dx_rs1_i(dx_rs1), .dx_rs2_i(dx_rs2), .dx_rd_i(dx_rd), .dx_imm_i(dx_imm),
		.dx_alu_op_i(dx_alu_op), .dx_src_b_i(dx_src_b), .dx_mem_op_i(dx_mem_op),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.mw_rd_i(mw_rd), .mw_result_i(mw_result), .wx_rd_i(wx_rd), .wx_result_i(wx_result),
		.m_stall_i(m_stall), .x_stall_o(x_stall),
		.data_req_o(data_req), .data_addr_o(data_addr), .data_write_o(data_write),
		.xm_rd_o(xm_rd), .xm_rs2_o(xm_rs2), .xm_result_o(xm_result),
		.xm_store_data_o(xm_store_data), .xm_mem_op_o(xm_mem_op)
	);

	rv_mem_stage u_mem_stage (
		.clk(clk), .rst_n(rst_n),
		.xm_rd_i(xm_rd), .xm_rs2_i(xm_rs2), .xm_result_i(xm_result),
		.xm_store_data_i(xm_store_data), .xm_mem_op_i(xm_mem_op),
		.hrdata_i(ahb_hrdata_i), .m_stall_i(m_stall), .hwdata_o(ahb_hwdata_o),
		.mw_rd_o(mw_rd), .mw_result_o(mw_result), .wx_rd_o(wx_rd), .wx_result_o(wx_result)
	);

	rv_ahb_master u_ahb_master (
		.clk(clk), .rst_n(rst_n), .hready_i(ahb_hready_i),
		.data_req_i(data_req), .data_addr_i(data_addr), .data_write_i(data_write),
		.fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
		.htrans_o(ahb_htrans_o), .haddr_o(ahb_haddr_o), .hwrite_o(ahb_hwrite_o),
		.hsize_o(ahb_hsize_o), .fetch_grant_o(fetch_grant),
		.fetch_rdata_valid_o(fetch_rdata_valid), .m_stall_o(m_stall)
	);

endmodule

// ==== include/tb_ref_model.svh ====
// Program generator and RV32I reference model, included inside the core testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

	function automatic int rnd(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Source register, x1 holds the data base and is never picked
	function automatic logic [4:0] src_reg();
		logic [4:0] r;
		r = 5'(rnd(16));
		return (r == 5'd1) ? 5'd0 : r;
	endfunction

	function automatic logic [4:0] dst_reg();
		return 5'(2 + rnd(14));
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic void emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endfunction

	// Setup of all used registers, then a random body and a NOP tail
	function automatic void gen_program();
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          kind;
		emit({DATA_BASE[31:12], 5'd1, 7'b0110111});
		for (int r = 2; r < 16; r++) begin
			emit({20'($random(seed)), 5'(r), 7'b0110111});
			emit(enc_i(12'($random(seed)), 5'(r), 3'b000, 5'(r), 7'b0010011));
		end
		while (prog_len < 190) begin
			kind = rnd(8);
			rd   = dst_reg();
			f3   = 3'(rnd(8));
			if (kind < 2) begin
				emit(enc_r(((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00,
					src_reg(), src_reg(), f3, rd));
			end else if (kind < 4) begin
				imm = 12'($random(seed));
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm = {(f3 == 3'd5 && rnd(2) == 1) ? 7'h20 : 7'h00, 5'(rnd(32))};
				end
				emit(enc_i(imm, src_reg(), f3, rd, 7'b0010011));
			end else if (kind == 4) begin
				emit({20'($random(seed)), rd, 7'b0110111});
			end else if (kind == 5) begin
				emit(enc_i(12'(4 * rnd(64)), 5'd1, 3'b010, rd, 7'b0000011));
				// Immediate consumer of the loaded value
				if (rnd(2) == 1) begin
					emit(enc_r(7'h00, src_reg(), rd, 3'b000, dst_reg()));
				end
			end else begin
				emit(enc_sw(12'(4 * rnd(64)), src_reg()));
			end
			// Store right behind its producer
			if (kind < 5 && rnd(2) == 1) begin
				emit(enc_sw(12'(4 * rnd(64)), rd));
			end
		end
		for (int i = 0; i < 8; i++) begin
			emit(32'h0000_0013);
		end
	endfunction

	// Runs the program in order and records every store as address and data
	function automatic void ref_run();
		logic [31:0] x [32];
		logic [31:0] dmem [64];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] imm;
		logic [31:0] addr;
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		for (int j = 0; j < 64; j++) begin
			dmem[j] = init_word(DATA_BASE + 32'(4 * j));
		end
		for (int i = 0; i < prog_len; i++) begin
			w   = prog[i];
			a   = x[w[19:15]];
			imm = {{20{w[31]}}, w[31:20]};
			b   = (w[6:0] == 7'b0110011) ? x[w[24:20]] : imm;
			case (w[14:12])
				3'd0: res = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
				3'd1: res = a << b[4:0];
				3'd2: res = {31'd0, $signed(a) < $signed(b)};
				3'd3: res = {31'd0, a < b};
				3'd4: res = a ^ b;
				3'd5: begin
					res = a >> b[4:0];
					if (w[30]) begin
						res = $signed(a) >>> b[4:0];
					end
				end
				3'd6: res = a | b;
				default: res = a & b;
			endcase
			if (w[6:0] == 7'b0110111) begin
				res = {w[31:12], 12'h000};
			end
			if (w[6:0] == 7'b0000011) begin
				addr = a + imm;
				res  = dmem[addr[7:2]];
			end
			if (w[6:0] == 7'b0100011) begin
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				dmem[addr[7:2]] = x[w[24:20]];
				exp_addr.push_back(addr);
				exp_data.push_back(x[w[24:20]]);
			end else begin
				x[w[11:7]] = res;
			end
			x[0] = '0;
		end
	endfunction

`endif

// ==== tests/tb_rv_core.sv ====
// Testbench for the RV32I core, runs a random program on an AHB-lite memory and checks the stores
module tb_rv_core import rv_core_pkg::*; ();

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
	localparam logic [31:0] DATA_BASE    = 32'h0000_1000;
	localparam logic [31:0] DATA_END     = 32'h0000_1100;
	localparam int          MAX_WAIT     = 3;

	logic        clk;
	logic        rst_n;
	logic        hready;
	logic [31:0] hrdata;
	logic [31:0] haddr;
	logic        hwrite;
	htrans_e     htrans;
	logic [2:0]  hsize;
	logic [31:0] hwdata;

	integer      seed = 32'h57322a7c;
	logic [31:0] prog [256];
	int          prog_len = 0;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] act_addr [$];
	logic [31:0] act_data [$];
	logic [31:0] mem [2048];
	logic        gen_done = 1'b0;

	// Data phase currently on the bus
	logic        ph_valid = 1'b0;
	logic        ph_write = 1'b0;
	logic [31:0] ph_addr  = '0;
	logic [31:0] exp_fetch = RESET_VECTOR;
	int          wait_cnt = 0;

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h5a3c_96e1;
	endfunction

`include "tb_ref_model.svh"

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	rv_core #(.RESET_VECTOR(RESET_VECTOR)) uut (
		.clk(clk), .rst_n(rst_n),
		.ahb_hready_i(hready), .ahb_hrdata_i(hrdata),
		.ahb_haddr_o(haddr), .ahb_hwrite_o(hwrite), .ahb_htrans_o(htrans),
		.ahb_hsize_o(hsize), .ahb_hwdata_o(hwdata)
	);

	always #2 clk = ~clk;

	// ====================
	// Stimulus and memory
	// ====================
	initial begin
		clk    = 1'b0;
		rst_n  = 1'b0;
		hready = 1'b1;
		hrdata = '0;
		gen_program();
		ref_run();
		for (int i = 0; i < 2048; i++) begin
			mem[i] = init_word(32'(4 * i));
		end
		for (int i = 0; i < DATA_BASE / 4; i++) begin
			mem[i] = (i < prog_len) ? prog[i] : 32'h0000_0013;
		end
		gen_done = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	// Wait states only while a data phase is pending, at most MAX_WAIT in a row
	always @(negedge clk) begin
		if (rst_n && ph_valid && wait_cnt < MAX_WAIT && rnd(3) == 0) begin
			hready = 1'b0;
			wait_cnt++;
		end else begin
			hready   = 1'b1;
			wait_cnt = 0;
		end
		hrdata = (ph_valid && !ph_write) ? mem[ph_addr[12:2]] : '0;
	end

	always @(posedge clk) begin
		if (rst_n && hready) begin
			if (ph_valid && ph_write) begin
				mem[ph_addr[12:2]] = hwdata;
				act_addr.push_back(ph_addr);
				act_data.push_back(hwdata);
			end
			ph_valid = 1'b0;
			if (htrans == 2'b10) begin
				check("hsize", 32'(3'b010), 32'(hsize));
				if (hwrite && (haddr < DATA_BASE || haddr >= DATA_END)) begin
					report_failure("a write went outside the data region");
				end
				if (!hwrite && haddr < DATA_BASE) begin
					check("fetch address", exp_fetch, haddr);
					exp_fetch = exp_fetch + 32'd4;
				end
				ph_valid = 1'b1;
				ph_write = hwrite;
				ph_addr  = haddr;
			end
		end
	end

	// ====================
	// Compare and watchdog
	// ====================
	initial begin
		int n_checked;
		n_checked = 0;
		wait (gen_done);
		while (n_checked < exp_addr.size()) begin
			@(negedge clk);
			while (act_addr.size() > 0 && n_checked < exp_addr.size()) begin
				check($sformatf("store %0d address", n_checked), exp_addr[n_checked],
					act_addr.pop_front());
				check($sformatf("store %0d data", n_checked), exp_data[n_checked],
					act_data.pop_front());
				n_checked++;
			end
		end
		$display("Everything OK");
		$finish;
	end

	initial begin
		wait (gen_done);
		repeat (prog_len * (MAX_WAIT + 1) * 8 + 100) @(posedge clk);
		report_failure("timeout, the core did not finish the program");
	end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_mem_stage.sv
hdl/rv_ahb_master.sv
hdl/rv_core.sv
tests/tb_rv_core.sv
